/* filelist.f */
common/vtp_pkg.sv
hdl/stat_counter.sv
vtp_csr/vtp_csr.sv
hdl/vtp_csr_top.sv
dv/clock_gen.sv
dv/csr_checker.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
# Builds the VTP CSR testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_top -f filelist.f -o tb_sim

sim_out=$(./obj_dir/tb_sim 2>&1) || true
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx 'PASS: all tests'; then
    exit 0
fi
exit 1

/* dv/tb_top.sv */
// Testbench top for the VTP CSR block, driving the register port and engine events and predicting reads
`timescale 1ns/100ps
`default_nettype none

module tb_top;

    logic clk;
    logic reset;

    vtp_pkg::csr_req_t csr_req;
    vtp_pkg::csr_rsp_t csr_rsp;
    logic [vtp_pkg::csr_data_bits-1:0] dfh_value;
    vtp_pkg::tlb_events_t tlb_events;
    vtp_pkg::walk_events_t walk_events;
    vtp_pkg::vtp_out_mode_t out_mode;
    vtp_pkg::vtp_ctrl_t ctrl;

    // Expectations handed to the checker with each request
    logic [vtp_pkg::csr_data_bits-1:0] exp_rd_data;
    logic [3:0] exp_pulse;
    logic [vtp_pkg::cl_addr_bits-1:0] exp_pulse_data;
    logic state_check;
    vtp_pkg::vtp_in_mode_t exp_in_mode;
    logic exp_pt_valid;
    logic [vtp_pkg::cl_addr_bits-1:0] exp_pt_base;
    logic [2:0] test_id;
    logic test_done;
    logic run_done;
    logic finished;
    logic timed_out;
    logic [31:0] error_total;

    // Strobes driven on each statistic, in register order from index 4
    logic [63:0] totals [6];

    clock_gen clock_gen_inst
    (
        .clk(clk),
        .reset(reset)
    );

    vtp_csr_top
    #(
        .enable_vtp(1)
    )
    vtp_csr_top_inst
    (
        .clk(clk),
        .reset(reset),
        .csr_req(csr_req),
        .csr_rsp(csr_rsp),
        .dfh_value(dfh_value),
        .tlb_events(tlb_events),
        .walk_events(walk_events),
        .out_mode(out_mode),
        .ctrl(ctrl)
    );

    csr_checker csr_checker_inst
    (
        .clk(clk),
        .reset(reset),
        .csr_req(csr_req),
        .csr_rsp(csr_rsp),
        .ctrl(ctrl),
        .exp_rd_data(exp_rd_data),
        .exp_pulse(exp_pulse),
        .exp_pulse_data(exp_pulse_data),
        .state_check(state_check),
        .exp_in_mode(exp_in_mode),
        .exp_pt_valid(exp_pt_valid),
        .exp_pt_base(exp_pt_base),
        .test_id(test_id),
        .test_done(test_done),
        .run_done(run_done),
        .finished(finished),
        .error_total(error_total),
        .timed_out(timed_out)
    );

    // Expected read data for an index, built from the register map and the driven history
    function automatic logic [63:0] expected_read(input logic [3:0] idx);
        logic [127:0] uuid;
        uuid = vtp_pkg::vtp_block_uuid;
        case (idx)
            vtp_pkg::csr_idx_dfh: return dfh_value;
            vtp_pkg::csr_idx_uuid_lo: return uuid[63:0];
            vtp_pkg::csr_idx_uuid_hi: return uuid[127:64];
            vtp_pkg::csr_idx_mode: return {61'd0, out_mode};
            vtp_pkg::csr_idx_hit_4kb: return totals[0];
            vtp_pkg::csr_idx_miss_4kb: return totals[1];
            vtp_pkg::csr_idx_hit_2mb: return totals[2];
            vtp_pkg::csr_idx_miss_2mb: return totals[3];
            vtp_pkg::csr_idx_walk_busy: return totals[4];
            vtp_pkg::csr_idx_failed: return totals[5];
            vtp_pkg::csr_idx_last_vaddr: return {22'd0, walk_events.last_vaddr};
            default: return 64'd0;
        endcase
    endfunction

    // Moves to 1 ns after the next rising edge and drops every one-cycle strobe
    task automatic step();
        @(posedge clk);
        #1;
        csr_req.rd_req_en = 1'b0;
        csr_req.wr_req_en = 1'b0;
        exp_pulse = '0;
        state_check = 1'b0;
        test_done = 1'b0;
    endtask

    task automatic drive_read(input logic [3:0] idx);
        step();
        csr_req.rd_req_en = 1'b1;
        csr_req.idx = idx;
        exp_rd_data = expected_read(idx);
    endtask

    task automatic drive_write(input logic [3:0] idx, input logic [63:0] data,
                               input logic [3:0] pulses, input logic [41:0] pulse_addr);
        step();
        csr_req.wr_req_en = 1'b1;
        csr_req.idx = idx;
        csr_req.wr_data = data;
        exp_pulse = pulses;
        exp_pulse_data = pulse_addr;
    endtask

    task automatic check_state();
        step();
        state_check = 1'b1;
    endtask

    // Same as check_state, with the in_mode expected in that very cycle
    task automatic check_mode(input vtp_pkg::vtp_in_mode_t mode);
        step();
        state_check = 1'b1;
        exp_in_mode = mode;
    endtask

    // Reads all sixteen entries, back to back or with an idle cycle between them
    task automatic read_all(input logic gap);
        for (int i = 0; i < vtp_pkg::csr_n_entries; i++)
        begin
            drive_read(i[3:0]);
            if (gap)
            begin
                step();
            end
        end
        // The last response lands one cycle after its request
        step();
    endtask

    // The extra step keeps the test id steady until the checker has printed the line
    task automatic finish_test();
        step();
        test_done = 1'b1;
        step();
    endtask

    function automatic logic [63:0] random_word();
        return {$urandom(), $urandom()};
    endfunction

    initial
    begin : test_sequence
        logic [31:0] r;
        logic [63:0] wide;
        logic [5:0] strobes;

        r = $urandom(87653);
        csr_req = '0;
        dfh_value = random_word();
        tlb_events = '0;
        walk_events = '0;
        wide = random_word();
        walk_events.last_vaddr = wide[41:0];
        r = $urandom();
        out_mode = r[2:0];
        exp_rd_data = '0;
        exp_pulse = '0;
        exp_pulse_data = '0;
        state_check = 1'b0;
        exp_in_mode = '0;
        exp_pt_valid = 1'b0;
        exp_pt_base = '0;
        test_id = 3'd0;
        test_done = 1'b0;
        run_done = 1'b0;
        for (int i = 0; i < 6; i++)
        begin
            totals[i] = 64'd0;
        end
        wait (reset == 1'b0);

        // Reset values and a back-to-back read of every entry
        test_id = 3'd1;
        check_state();
        read_all(1'b0);
        finish_test();

        // Random event strobes, then a quiet gap before the counters are read
        test_id = 3'd2;
        for (int c = 0; c < 500; c++)
        begin
            step();
            r = $urandom();
            tlb_events = r[3:0];
            walk_events.busy = r[4];
            walk_events.failed_translation = (r[7:5] == 3'd0);
            if (walk_events.failed_translation)
            begin
                wide = random_word();
                walk_events.last_vaddr = wide[41:0];
            end
            strobes = {walk_events.failed_translation, walk_events.busy, tlb_events.miss_2mb,
                       tlb_events.hit_2mb, tlb_events.miss_4kb, tlb_events.hit_4kb};
            for (int i = 0; i < 6; i++)
            begin
                if (strobes[i])
                begin
                    totals[i] = totals[i] + 64'd1;
                end
            end
        end
        step();
        tlb_events = '0;
        walk_events.busy = 1'b0;
        walk_events.failed_translation = 1'b0;
        repeat (4) step();
        read_all(1'b1);
        finish_test();

        // Mode takes effect on the second edge, and the flush lasts one cycle
        test_id = 3'd3;
        wide = random_word();
        drive_write(vtp_pkg::csr_idx_mode, {wide[63:4], 4'b0001}, 4'b0000, 42'd0);
        check_mode(4'b0000);
        check_mode(4'b0001);
        drive_write(vtp_pkg::csr_idx_mode, 64'h3, 4'b0001, 42'd1);
        check_mode(4'b0001);
        check_mode(4'b0011);
        check_mode(4'b0001);
        finish_test();

        // Page table base stays valid, the three commands pulse back to back
        test_id = 3'd4;
        wide = random_word();
        drive_write(vtp_pkg::csr_idx_pt_base, wide, 4'b0000, 42'd0);
        step();
        exp_pt_valid = 1'b1;
        exp_pt_base = wide[41:0];
        check_state();
        wide = random_word();
        drive_write(vtp_pkg::csr_idx_inval_page, wide, 4'b0010, wide[41:0]);
        wide = random_word();
        drive_write(vtp_pkg::csr_idx_xlate_buf, wide, 4'b0100, wide[41:0]);
        wide = random_word();
        drive_write(vtp_pkg::csr_idx_xlate_rsp, wide, 4'b1000, wide[41:0]);
        repeat (3) step();
        check_state();
        finish_test();

        // Writes to read-only and unused entries must leave outputs and reads alone
        // The mode entry is writable and is not part of this group
        test_id = 3'd5;
        for (int i = 0; i < vtp_pkg::csr_n_entries; i++)
        begin
            if ((i <= 10 && i != vtp_pkg::csr_idx_mode) || i == 15)
            begin
                drive_write(i[3:0], random_word(), 4'b0000, 42'd0);
            end
        end
        repeat (3) step();
        check_state();
        read_all(1'b0);
        finish_test();

        run_done = 1'b1;
        wait (finished == 1'b1);
        if (error_total == 32'd0)
        begin
            $display("PASS: all tests");
        end
        else
        begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // The checker raises timed_out after printing what went wrong
    initial
    begin
        wait (timed_out === 1'b1);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/csr_checker.sv */
// Checker that watches the VTP CSR ports, compares reads and control outputs and reports results
`timescale 1ns/100ps
`default_nettype none

module csr_checker
(
    input wire logic clk,
    input wire logic reset,
    input wire vtp_pkg::csr_req_t csr_req,
    input wire vtp_pkg::csr_rsp_t csr_rsp,
    input wire vtp_pkg::vtp_ctrl_t ctrl,

    // Expectations, each driven in the same cycle as the request that causes it
    input wire logic [vtp_pkg::csr_data_bits-1:0] exp_rd_data,
    input wire logic [3:0] exp_pulse,
    input wire logic [vtp_pkg::cl_addr_bits-1:0] exp_pulse_data,
    input wire logic state_check,
    input wire vtp_pkg::vtp_in_mode_t exp_in_mode,
    input wire logic exp_pt_valid,
    input wire logic [vtp_pkg::cl_addr_bits-1:0] exp_pt_base,
    input wire logic [2:0] test_id,
    input wire logic test_done,
    input wire logic run_done,
    output logic finished,
    output logic [31:0] error_total,
    output logic timed_out
);

    // The whole sequence runs well under two thousand cycles
    localparam int cycle_limit = 20000;

    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int test_first_check = 0;
    int test_first_error = 0;
    logic run_finished = 1'b0;

    // A read request and its expected data, held until the response cycle
    logic rd_req_q;
    logic [vtp_pkg::csr_idx_bits-1:0] rd_idx_q;
    logic [vtp_pkg::csr_data_bits-1:0] exp_rd_q;

    // Pulse expectations delayed to the second edge after the write, where the DUT applies it
    logic [3:0] exp_pulse_q1;
    logic [3:0] exp_pulse_q2;
    logic [vtp_pkg::cl_addr_bits-1:0] exp_pulse_data_q1;
    logic [vtp_pkg::cl_addr_bits-1:0] exp_pulse_data_q2;

    // Pulse outputs in the order flush, page invalidate, translation buffer, translation response
    logic [3:0] got_pulse;
    logic [3:0][vtp_pkg::cl_addr_bits-1:0] got_pulse_data;

    assign got_pulse = {ctrl.xlate_rsp_valid, ctrl.xlate_buf_paddr_valid,
                        ctrl.inval_page_valid, ctrl.in_mode.inval_translation_cache};
    // The flush carries no address, so its data slot holds the enabled bit that must stay set
    assign got_pulse_data = {ctrl.xlate_rsp, ctrl.xlate_buf_paddr, ctrl.inval_page,
                             {{(vtp_pkg::cl_addr_bits-1){1'b0}}, ctrl.in_mode.enabled}};
    assign finished = run_finished;
    assign error_total = errors;

    function automatic string test_name(input logic [2:0] id);
        case (id)
            3'd1: return "reset_reads";
            3'd2: return "event_counts";
            3'd3: return "mode_write";
            3'd4: return "command_writes";
            3'd5: return "read_only_writes";
            default: return "setup";
        endcase
    endfunction

    function automatic string pulse_name(input int k);
        case (k)
            0: return "in_mode.inval_translation_cache";
            1: return "inval_page_valid";
            2: return "xlate_buf_paddr_valid";
            default: return "xlate_rsp_valid";
        endcase
    endfunction

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks = checks + 1;
        if (actual !== expected)
        begin
            errors = errors + 1;
            $display("Fail %s: %s expected 0x%0h actual 0x%0h",
                     test_name(test_id), what, expected, actual);
        end
    endtask

    always @(posedge clk)
    begin
        if (reset)
        begin
            rd_req_q <= 1'b0;
            exp_pulse_q1 <= '0;
            exp_pulse_q2 <= '0;
            timed_out <= 1'b0;
        end
        else
        begin
            rd_req_q <= csr_req.rd_req_en;
            exp_pulse_q1 <= exp_pulse;
            exp_pulse_q2 <= exp_pulse_q1;
        end
        rd_idx_q <= csr_req.idx;
        exp_rd_q <= exp_rd_data;
        exp_pulse_data_q1 <= exp_pulse_data;
        exp_pulse_data_q2 <= exp_pulse_data_q1;

        cycles <= cycles + 1;
        if (cycles == cycle_limit)
        begin
            $display("Timeout: test sequence did not end within %0d cycles", cycle_limit);
            timed_out <= 1'b1;
        end
    end

    // Outputs are compared mid-cycle, away from the edges where they and the inputs change
    always @(negedge clk)
    begin
        if (!reset)
        begin
            // A response must come exactly one cycle after each read request
            if (rd_req_q || csr_rsp.rd_rsp_valid)
            begin
                compare("rd_rsp_valid", 64'(rd_req_q), 64'(csr_rsp.rd_rsp_valid));
            end
            if (rd_req_q && csr_rsp.rd_rsp_valid)
            begin
                compare($sformatf("read of index %0d", rd_idx_q), exp_rd_q, csr_rsp.rd_data);
            end

            // Any pulse that rises unasked, or fails to rise, is a mismatch on its valid
            for (int k = 0; k < 4; k++)
            begin
                if (exp_pulse_q2[k] || got_pulse[k])
                begin
                    compare(pulse_name(k), 64'(exp_pulse_q2[k]), 64'(got_pulse[k]));
                end
                if (exp_pulse_q2[k] && got_pulse[k])
                begin
                    compare({pulse_name(k), " data"}, 64'(exp_pulse_data_q2),
                            64'(got_pulse_data[k]));
                end
            end

            if (state_check)
            begin
                compare("in_mode", 64'(exp_in_mode), 64'(ctrl.in_mode));
                compare("page_table_base_valid", 64'(exp_pt_valid),
                        64'(ctrl.page_table_base_valid));
                if (exp_pt_valid)
                begin
                    compare("page_table_base", 64'(exp_pt_base), 64'(ctrl.page_table_base));
                end
            end

            if (test_done)
            begin
                tests = tests + 1;
                $display("Test %s: %0d checks, %0d errors", test_name(test_id),
                         checks - test_first_check, errors - test_first_error);
                test_first_check = checks;
                test_first_error = errors;
            end

            if (run_done && !run_finished)
            begin
                $display("Totals: %0d tests, %0d checks, %0d errors", tests, checks, errors);
                run_finished = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* dv/clock_gen.sv */
// Testbench clock and reset source with a 10 ns period and a reset held for the first two cycles
`timescale 1ns/100ps
`default_nettype none

module clock_gen
#(
    parameter int half_period = 5,
    parameter int reset_cycles = 2
)
(
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Reset drops just after an edge, like every other driven input
    initial
    begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

/* hdl/vtp_csr_top.sv */
// VTP CSR top level that connects the host register port and the engine signals to the register block
`timescale 1ns/100ps
`default_nettype none

module vtp_csr_top
#(
    parameter int enable_vtp = 0
)
(
    input wire logic clk,
    input wire logic reset,

    // Host register port, mapped into MMIO space outside this block
    input wire vtp_pkg::csr_req_t csr_req,
    output vtp_pkg::csr_rsp_t csr_rsp,
    input wire logic [vtp_pkg::csr_data_bits-1:0] dfh_value,

    // Translation engine, TLB and page walker side
    input wire vtp_pkg::tlb_events_t tlb_events,
    input wire vtp_pkg::walk_events_t walk_events,
    input wire vtp_pkg::vtp_out_mode_t out_mode,
    output vtp_pkg::vtp_ctrl_t ctrl
);

    // No registers here, so port latency is that of the register block
    vtp_csr
    #(
        .enable_vtp(enable_vtp)
    )
    vtp_csr_inst
    (
        .clk(clk),
        .reset(reset),
        .csr_req(csr_req),
        .csr_rsp(csr_rsp),
        .dfh_value(dfh_value),
        .tlb_events(tlb_events),
        .walk_events(walk_events),
        .out_mode(out_mode),
        .ctrl(ctrl)
    );

endmodule

`default_nettype wire

/* vtp_csr/vtp_csr.sv */
// VTP register block that decodes host reads, applies host writes and keeps the event statistics
`timescale 1ns/100ps
`default_nettype none

module vtp_csr
#(
    parameter int enable_vtp = 0
)
(
    input wire logic clk,
    input wire logic reset,

    // Generic indexed register port
    input wire vtp_pkg::csr_req_t csr_req,
    output vtp_pkg::csr_rsp_t csr_rsp,

    // Header value supplied by the host, since only the host knows the MMIO layout
    input wire logic [vtp_pkg::csr_data_bits-1:0] dfh_value,

    // Engine side
    input wire vtp_pkg::tlb_events_t tlb_events,
    input wire vtp_pkg::walk_events_t walk_events,
    input wire vtp_pkg::vtp_out_mode_t out_mode,
    output vtp_pkg::vtp_ctrl_t ctrl
);

    // Identifier reads as zero when the shim is compiled out
    logic [127:0] block_uuid;
    assign block_uuid = (enable_vtp != 0) ? vtp_pkg::vtp_block_uuid : '0;

    // Event strobes in register order, starting at csr_idx_hit_4kb
    logic [vtp_pkg::stat_count-1:0] stat_incr;
    logic [vtp_pkg::stat_count-1:0][vtp_pkg::stat_bits-1:0] stat_value;

    assign stat_incr = {walk_events.failed_translation,
                        walk_events.busy,
                        tlb_events.miss_2mb,
                        tlb_events.hit_2mb,
                        tlb_events.miss_4kb,
                        tlb_events.hit_4kb};

    generate
        if (enable_vtp != 0)
        begin : gen_stats
            for (genvar i = 0; i < vtp_pkg::stat_count; i++)
            begin : gen_ctr
                stat_counter stat_counter_inst
                (
                    .clk(clk),
                    .reset(reset),
                    .incr(stat_incr[i]),
                    .value(stat_value[i])
                );
            end
        end
        else
        begin : gen_no_stats
            // No counters are built, all statistics read as zero
            assign stat_value = '0;
        end
    endgenerate

    // Zero-extended views of the narrower sources for the read mux
    logic [vtp_pkg::stat_count-1:0][vtp_pkg::csr_data_bits-1:0] stat_word;
    logic [vtp_pkg::csr_data_bits-1:0] mode_word;
    logic [vtp_pkg::csr_data_bits-1:0] vaddr_word;

    always_comb
    begin
        for (int i = 0; i < vtp_pkg::stat_count; i++)
        begin
            stat_word[i] = {{(vtp_pkg::csr_data_bits - vtp_pkg::stat_bits){1'b0}},
                            stat_value[i]};
        end
    end

    assign mode_word = {{(vtp_pkg::csr_data_bits - $bits(vtp_pkg::vtp_out_mode_t)){1'b0}},
                        out_mode};
    assign vaddr_word = {{(vtp_pkg::csr_data_bits - vtp_pkg::cl_addr_bits){1'b0}},
                         walk_events.last_vaddr};

    // Read path
    // The mux runs every cycle and the valid strobe follows the request by one cycle
    always_ff @(posedge clk)
    begin
        csr_rsp.rd_rsp_valid <= csr_req.rd_req_en;

        case (vtp_pkg::csr_index_e'(csr_req.idx))
            vtp_pkg::idx_dfh: csr_rsp.rd_data <= dfh_value;
            vtp_pkg::idx_uuid_lo: csr_rsp.rd_data <= block_uuid[63:0];
            vtp_pkg::idx_uuid_hi: csr_rsp.rd_data <= block_uuid[127:64];
            vtp_pkg::idx_mode: csr_rsp.rd_data <= mode_word;
            vtp_pkg::idx_hit_4kb: csr_rsp.rd_data <= stat_word[0];
            vtp_pkg::idx_miss_4kb: csr_rsp.rd_data <= stat_word[1];
            vtp_pkg::idx_hit_2mb: csr_rsp.rd_data <= stat_word[2];
            vtp_pkg::idx_miss_2mb: csr_rsp.rd_data <= stat_word[3];
            vtp_pkg::idx_walk_busy: csr_rsp.rd_data <= stat_word[4];
            vtp_pkg::idx_failed: csr_rsp.rd_data <= stat_word[5];
            vtp_pkg::idx_last_vaddr: csr_rsp.rd_data <= vaddr_word;
            // Write-only entries and index 15 read back as zero
            default: csr_rsp.rd_data <= '0;
        endcase

        if (reset)
        begin
            csr_rsp.rd_rsp_valid <= 1'b0;
        end
    end

    // Write path
    // One buffer stage so the index compare does not sit on the host's timing path
    logic wr_req_en_q;
    logic [vtp_pkg::csr_idx_bits-1:0] wr_idx_q;
    logic [vtp_pkg::cl_addr_bits-1:0] wr_data_q;

    always_ff @(posedge clk)
    begin
        wr_req_en_q <= csr_req.wr_req_en;
        wr_idx_q <= csr_req.idx;
        // Only the address-sized low bits of written data feed any register
        wr_data_q <= csr_req.wr_data[vtp_pkg::cl_addr_bits-1:0];

        if (reset)
        begin
            wr_req_en_q <= 1'b0;
        end
    end

    // Decoded write targets, at most one is high
    logic wr_mode;
    logic wr_pt_base;
    logic wr_inval_page;
    logic wr_xlate_buf;
    logic wr_xlate_rsp;

    always_comb
    begin
        wr_mode = 1'b0;
        wr_pt_base = 1'b0;
        wr_inval_page = 1'b0;
        wr_xlate_buf = 1'b0;
        wr_xlate_rsp = 1'b0;

        // Read-only and unused entries fall through and change nothing
        case (vtp_pkg::csr_index_e'(wr_idx_q))
            vtp_pkg::idx_mode: wr_mode = wr_req_en_q;
            vtp_pkg::idx_pt_base: wr_pt_base = wr_req_en_q;
            vtp_pkg::idx_inval_page: wr_inval_page = wr_req_en_q;
            vtp_pkg::idx_xlate_buf: wr_xlate_buf = wr_req_en_q;
            vtp_pkg::idx_xlate_rsp: wr_xlate_rsp = wr_req_en_q;
            default: ;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (wr_mode)
        begin
            ctrl.in_mode <=
                vtp_pkg::vtp_in_mode_t'(wr_data_q[$bits(vtp_pkg::vtp_in_mode_t)-1:0]);
        end
        else
        begin
            // Cache flush is a request, so it drops after one cycle
            ctrl.in_mode.inval_translation_cache <= 1'b0;
        end

        // Page table base stays valid once it has been written
        if (wr_pt_base)
        begin
            ctrl.page_table_base <= wr_data_q;
            ctrl.page_table_base_valid <= 1'b1;
        end

        // The three commands carry their address with a one-cycle valid
        ctrl.inval_page <= wr_data_q;
        ctrl.inval_page_valid <= wr_inval_page;
        ctrl.xlate_buf_paddr <= wr_data_q;
        ctrl.xlate_buf_paddr_valid <= wr_xlate_buf;
        ctrl.xlate_rsp <= wr_data_q;
        ctrl.xlate_rsp_valid <= wr_xlate_rsp;

        if (reset)
        begin
            ctrl.in_mode <= '0;
            ctrl.page_table_base_valid <= 1'b0;
            ctrl.inval_page_valid <= 1'b0;
            ctrl.xlate_buf_paddr_valid <= 1'b0;
            ctrl.xlate_rsp_valid <= 1'b0;
        end
    end

    // The host never reads and writes in the same cycle
    a_no_rd_wr_overlap: assert property (
        @(posedge clk) disable iff (reset)
        !(csr_req.rd_req_en && csr_req.wr_req_en))
    else
        $error("read and write requested in the same cycle");

    // A pulse held for two cycles needs two writes to its index back to back
    // The requests sit two and three edges behind the pulse at the host port
    a_flush_pulse: assert property (
        @(posedge clk) disable iff (reset)
        ctrl.in_mode.inval_translation_cache && $past(ctrl.in_mode.inval_translation_cache)
        |-> $past(csr_req.wr_req_en && csr_req.idx == vtp_pkg::csr_idx_mode, 2)
            && $past(csr_req.wr_req_en && csr_req.idx == vtp_pkg::csr_idx_mode, 3))
    else
        $error("cache flush held without back-to-back writes");

    a_inval_pulse: assert property (
        @(posedge clk) disable iff (reset)
        ctrl.inval_page_valid && $past(ctrl.inval_page_valid)
        |-> $past(csr_req.wr_req_en && csr_req.idx == vtp_pkg::csr_idx_inval_page, 2)
            && $past(csr_req.wr_req_en && csr_req.idx == vtp_pkg::csr_idx_inval_page, 3))
    else
        $error("inval_page_valid held without back-to-back writes");

    a_xlate_buf_pulse: assert property (
        @(posedge clk) disable iff (reset)
        ctrl.xlate_buf_paddr_valid && $past(ctrl.xlate_buf_paddr_valid)
        |-> $past(csr_req.wr_req_en && csr_req.idx == vtp_pkg::csr_idx_xlate_buf, 2)
            && $past(csr_req.wr_req_en && csr_req.idx == vtp_pkg::csr_idx_xlate_buf, 3))
    else
        $error("xlate_buf_paddr_valid held without back-to-back writes");

    a_xlate_rsp_pulse: assert property (
        @(posedge clk) disable iff (reset)
        ctrl.xlate_rsp_valid && $past(ctrl.xlate_rsp_valid)
        |-> $past(csr_req.wr_req_en && csr_req.idx == vtp_pkg::csr_idx_xlate_rsp, 2)
            && $past(csr_req.wr_req_en && csr_req.idx == vtp_pkg::csr_idx_xlate_rsp, 3))
    else
        $error("xlate_rsp_valid held without back-to-back writes");

endmodule

`default_nettype wire

/* hdl/stat_counter.sv */
// Statistics counter that accumulates a one-bit event strobe over a two-stage split add
`timescale 1ns/100ps
`default_nettype none

module stat_counter
(
    input wire logic clk,
    input wire logic reset,
    input wire logic incr,
    output logic [vtp_pkg::stat_bits-1:0] value
);

    // Strobe registered once so the adder sees a flop at its input
    logic incr_q;

    // Lower half and the carry it produces
    logic [vtp_pkg::stat_low_bits-1:0] low_q;
    logic carry_q;

    // Upper half trails the lower half by one cycle
    logic [vtp_pkg::stat_high_bits-1:0] high_q;

    // Copy of the lower half delayed to line up with the upper half
    logic [vtp_pkg::stat_low_bits-1:0] low_aligned_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            incr_q <= 1'b0;
            low_q <= '0;
            carry_q <= 1'b0;
            high_q <= '0;
            low_aligned_q <= '0;
        end
        else
        begin
            incr_q <= incr;
            {carry_q, low_q} <= {1'b0, low_q} + {{vtp_pkg::stat_low_bits{1'b0}}, incr_q};
            // Carry out of the lower half lands here one cycle after it was made
            high_q <= high_q + {{(vtp_pkg::stat_high_bits-1){1'b0}}, carry_q};
            low_aligned_q <= low_q;
        end
    end

    // Both halves come from the same add, so a wrap of the lower half
    // never shows up before its carry does
    assign value = {high_q, low_aligned_q};

    // The split halves must never make the visible total step backwards
    a_value_monotonic: assert property (
        @(posedge clk) disable iff (reset)
        !$past(reset) |-> value >= $past(value))
    else
        $error("stat_counter value went backwards");

endmodule

`default_nettype wire

/* common/vtp_pkg.sv */
// VTP CSR package with the register map, field widths and the structs shared by the CSR blocks
`default_nettype none

package vtp_pkg;

    // Register space is a flat array of 64-bit entries
    localparam int csr_n_entries = 16;
    localparam int csr_idx_bits = $clog2(csr_n_entries);
    localparam int csr_data_bits = 64;

    // Statistics counters are split in two halves for the pipelined add
    localparam int stat_bits = 54;
    localparam int stat_low_bits = 27;
    localparam int stat_high_bits = stat_bits - stat_low_bits;
    localparam int stat_count = 6;

    // Physical and virtual addresses are carried as cache-line addresses
    localparam int cl_addr_bits = 42;

    // Block identifier, reported at indices 1 and 2
    localparam logic [127:0] vtp_block_uuid = 128'hc8a2982f_ff96_42bf_a705_45727f501901;

    // Register index map
    localparam logic [csr_idx_bits-1:0] csr_idx_dfh = 4'd0;
    localparam logic [csr_idx_bits-1:0] csr_idx_uuid_lo = 4'd1;
    localparam logic [csr_idx_bits-1:0] csr_idx_uuid_hi = 4'd2;
    localparam logic [csr_idx_bits-1:0] csr_idx_mode = 4'd3;
    localparam logic [csr_idx_bits-1:0] csr_idx_hit_4kb = 4'd4;
    localparam logic [csr_idx_bits-1:0] csr_idx_miss_4kb = 4'd5;
    localparam logic [csr_idx_bits-1:0] csr_idx_hit_2mb = 4'd6;
    localparam logic [csr_idx_bits-1:0] csr_idx_miss_2mb = 4'd7;
    localparam logic [csr_idx_bits-1:0] csr_idx_walk_busy = 4'd8;
    localparam logic [csr_idx_bits-1:0] csr_idx_failed = 4'd9;
    localparam logic [csr_idx_bits-1:0] csr_idx_last_vaddr = 4'd10;
    localparam logic [csr_idx_bits-1:0] csr_idx_pt_base = 4'd11;
    localparam logic [csr_idx_bits-1:0] csr_idx_inval_page = 4'd12;
    localparam logic [csr_idx_bits-1:0] csr_idx_xlate_buf = 4'd13;
    localparam logic [csr_idx_bits-1:0] csr_idx_xlate_rsp = 4'd14;

    // Index 15 has no entry and falls to the default arm of each decode
    typedef enum logic [csr_idx_bits-1:0] {
        idx_dfh = csr_idx_dfh,
        idx_uuid_lo = csr_idx_uuid_lo,
        idx_uuid_hi = csr_idx_uuid_hi,
        idx_mode = csr_idx_mode,
        idx_hit_4kb = csr_idx_hit_4kb,
        idx_miss_4kb = csr_idx_miss_4kb,
        idx_hit_2mb = csr_idx_hit_2mb,
        idx_miss_2mb = csr_idx_miss_2mb,
        idx_walk_busy = csr_idx_walk_busy,
        idx_failed = csr_idx_failed,
        idx_last_vaddr = csr_idx_last_vaddr,
        idx_pt_base = csr_idx_pt_base,
        idx_inval_page = csr_idx_inval_page,
        idx_xlate_buf = csr_idx_xlate_buf,
        idx_xlate_rsp = csr_idx_xlate_rsp
    } csr_index_e;

    // Host-written mode, enabled sits in bit 0 of the written data
    typedef struct packed {
        logic [1:0] reserved;
        logic inval_translation_cache;
        logic enabled;
    } vtp_in_mode_t;

    // Mode as reported back by the translation engine
    typedef struct packed {
        logic sw_translation_service;
        logic no_hw_page_walker;
        logic enabled;
    } vtp_out_mode_t;

    typedef struct packed {
        logic rd_req_en;
        logic wr_req_en;
        logic [csr_idx_bits-1:0] idx;
        logic [csr_data_bits-1:0] wr_data;
    } csr_req_t;

    typedef struct packed {
        logic rd_rsp_valid;
        logic [csr_data_bits-1:0] rd_data;
    } csr_rsp_t;

    // One strobe per TLB lookup outcome
    typedef struct packed {
        logic hit_4kb;
        logic miss_4kb;
        logic hit_2mb;
        logic miss_2mb;
    } tlb_events_t;

    typedef struct packed {
        logic busy;
        logic failed_translation;
        logic [cl_addr_bits-1:0] last_vaddr;
    } walk_events_t;

    // Control outputs toward the engine, the pulse valids last one cycle
    typedef struct packed {
        vtp_in_mode_t in_mode;
        logic [cl_addr_bits-1:0] page_table_base;
        logic page_table_base_valid;
        logic [cl_addr_bits-1:0] inval_page;
        logic inval_page_valid;
        logic [cl_addr_bits-1:0] xlate_buf_paddr;
        logic xlate_buf_paddr_valid;
        logic [cl_addr_bits-1:0] xlate_rsp;
        logic xlate_rsp_valid;
    } vtp_ctrl_t;

endpackage

`default_nettype wire
